/* free_list.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module free_list (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic [1:0]          alloc,
    input  rename_pkg::retire_t release_lanes [`RENAME_W],
    input  logic [`PHY_REGS-1:0] committed_mask,
    output rename_pkg::phys_reg_t alloc_phys [`RENAME_W],
    output logic                req_ready
);
    import rename_pkg::*;

    // one rebuild push plus one push per retire lane
    localparam int PUSH_N = `RENAME_W + 1;

    phys_reg_t queue [`PHY_REGS];
    phys_reg_t head;                 // oldest free entry
    phys_reg_t tail;                 // next slot to fill
    fl_count_t count;
    fl_state_t state;
    phys_reg_t scan_idx;             // register examined during rebuild
    logic      ready_q;

    phys_reg_t head_next;
    phys_reg_t tail_next;
    fl_count_t count_next;
    fl_state_t state_next;
    phys_reg_t scan_next;
    fl_count_t n_pop;
    fl_count_t n_push;

    logic      push_en  [PUSH_N];
    phys_reg_t push_reg [PUSH_N];
    phys_reg_t wr_idx   [PUSH_N];

    // lane 1 takes the second entry only when lane 0 also allocates
    assign alloc_phys[0] = queue[head];
    assign alloc_phys[1] = alloc[0] ? queue[head + 1'b1] : queue[head];

    assign req_ready = ready_q;

    always_comb begin
        n_pop = fl_count_t'(alloc[0]) + fl_count_t'(alloc[1]);

        // slot 0 is the rebuild scan, physical 0 never goes back on the list
        push_en[0]  = (state == FL_REBUILD) && (scan_idx != '0) && !committed_mask[scan_idx];
        push_reg[0] = scan_idx;
        for (int k = 0; k < `RENAME_W; k++) begin
            push_en[k+1]  = release_lanes[k].valid && (release_lanes[k].rd_arch != '0);
            push_reg[k+1] = release_lanes[k].rd_phy_old;
        end

        // pack the enabled pushes behind the tail in slot order
        tail_next = tail;
        n_push    = '0;
        for (int k = 0; k < PUSH_N; k++) begin
            wr_idx[k] = tail_next;
            if (push_en[k]) begin
                tail_next = tail_next + 1'b1;
                n_push    = n_push + 1'b1;
            end
        end

        head_next  = head + phys_reg_t'(n_pop);
        count_next = count + n_push - n_pop;
        state_next = state;
        scan_next  = scan_idx;

        if (state == FL_REBUILD) begin
            scan_next = scan_idx + 1'b1;
            if (scan_idx == phys_reg_t'(`PHY_REGS - 1)) begin
                state_next = FL_RUN;    // last register scanned
            end
        end

        // flush drops the queue and restarts the scan from 0
        if (flush) begin
            head_next  = '0;
            tail_next  = '0;
            count_next = '0;
            state_next = FL_REBUILD;
            scan_next  = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // entries 0..PHY_REGS-ARCH_REGS-1 hold ARCH_REGS and up
            for (int i = 0; i < `PHY_REGS; i++) begin
                queue[i] <= phys_reg_t'(i + `ARCH_REGS);
            end
            head     <= '0;
            tail     <= phys_reg_t'(`PHY_REGS - `ARCH_REGS);
            count    <= fl_count_t'(`PHY_REGS - `ARCH_REGS);
            state    <= FL_RUN;
            scan_idx <= '0;
            ready_q  <= 1'b0;
        end else begin
            for (int k = 0; k < PUSH_N; k++) begin
                if (push_en[k] && !flush) begin
                    queue[wr_idx[k]] <= push_reg[k];
                end
            end
            head     <= head_next;
            tail     <= tail_next;
            count    <= count_next;
            state    <= state_next;
            scan_idx <= scan_next;
            ready_q  <= (state_next == FL_RUN) && (count_next >= fl_count_t'(2));
        end
    end

    // the rename side must never take more than is on the list
    a_alloc_le_count: assert property (
        @(posedge clk) disable iff (rst)
        fl_count_t'($countones(alloc)) <= count
    );

    a_no_alloc_in_rebuild: assert property (
        @(posedge clk) disable iff (rst)
        (state == FL_REBUILD) |-> (alloc == 2'b00)
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= fl_count_t'(`PHY_REGS)
    );

endmodule

/* rename_macros.svh */
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural register file
`define ARCH_REGS 32
`define ARCH_W    5

// physical register file, entry 0 is hardwired to x0
`define PHY_REGS  64
`define PHY_W     6

// instructions renamed or retired per cycle
`define RENAME_W  2

`endif

/* rename_pkg.sv */
`include "rename_macros.svh"

package rename_pkg;

    typedef logic [`ARCH_W-1:0] arch_reg_t;   // architectural register number
    typedef logic [`PHY_W-1:0]  phys_reg_t;   // physical register number
    typedef logic [`PHY_W:0]    fl_count_t;   // free entries, 0..PHY_REGS

    // one instruction offered for rename
    typedef struct packed {
        logic      valid;
        arch_reg_t rd_arch;
        arch_reg_t rs1_arch;
        arch_reg_t rs2_arch;
    } rename_req_t;

    // rename result of one lane
    typedef struct packed {
        phys_reg_t rd_phy_new;
        phys_reg_t rd_phy_old;   // mapping being replaced, 0 if nothing written
        phys_reg_t rs1_phy;
        phys_reg_t rs2_phy;
    } rename_rsp_t;

    // one retiring instruction
    typedef struct packed {
        logic      valid;
        arch_reg_t rd_arch;
        phys_reg_t rd_phy_old;
        phys_reg_t rd_phy_new;
    } retire_t;

    typedef enum logic {
        FL_RUN,
        FL_REBUILD
    } fl_state_t;

endpackage

/* rename_unit.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  rename_pkg::rename_req_t req [`RENAME_W],
    input  rename_pkg::retire_t     retire [`RENAME_W],
    output logic                    req_ready,
    output rename_pkg::rename_rsp_t rsp [`RENAME_W]
);
    import rename_pkg::*;

    logic [1:0]           alloc;
    phys_reg_t            alloc_phys [`RENAME_W];
    phys_reg_t            committed_map [`ARCH_REGS];
    logic [`PHY_REGS-1:0] committed_mask;

    free_list i_free_list (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .alloc          (alloc),
        .release_lanes  (retire),
        .committed_mask (committed_mask),
        .alloc_phys     (alloc_phys),
        .req_ready      (req_ready)
    );

    spec_map_table i_spec_map_table (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .req           (req),
        .req_ready     (req_ready),
        .alloc_phys    (alloc_phys),
        .committed_map (committed_map),
        .alloc         (alloc),
        .rsp           (rsp)
    );

    retire_map_table i_retire_map_table (
        .clk            (clk),
        .rst            (rst),
        .retire         (retire),
        .committed_map  (committed_map),
        .committed_mask (committed_mask)
    );

    // flush must land on an otherwise idle cycle
    a_flush_idle: assert property (
        @(posedge clk) disable iff (rst)
        flush |-> !(req_ready && req[0].valid) && !retire[0].valid && !retire[1].valid
    );

endmodule

/* retire_map_table.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module retire_map_table (
    input  logic                  clk,
    input  logic                  rst,
    input  rename_pkg::retire_t   retire [`RENAME_W],
    output rename_pkg::phys_reg_t committed_map [`ARCH_REGS],
    output logic [`PHY_REGS-1:0]  committed_mask
);
    import rename_pkg::*;

    phys_reg_t           map_next [`ARCH_REGS];
    logic [`PHY_REGS-1:0] mask_next;
    phys_reg_t           old_exp1;     // committed entry seen by lane 1

    always_comb begin
        map_next = committed_map;
        // lane 1 applied after lane 0 so it wins on the same register
        for (int k = 0; k < `RENAME_W; k++) begin
            if (retire[k].valid && (retire[k].rd_arch != '0)) begin
                map_next[retire[k].rd_arch] = retire[k].rd_phy_new;
            end
        end

        // one bit per physical register held by the new map
        mask_next = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            mask_next[map_next[i]] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                committed_map[i] <= phys_reg_t'(i);
            end
            committed_mask <= {{(`PHY_REGS - `ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};
        end else begin
            committed_map  <= map_next;
            committed_mask <= mask_next;
        end
    end

    // lane 1 replaces lane 0's mapping if both retire the same register
    assign old_exp1 = (retire[0].valid && (retire[0].rd_arch == retire[1].rd_arch))
                    ? retire[0].rd_phy_new : committed_map[retire[1].rd_arch];

    // retire order must match the rename order seen by the map
    a_old_match0: assert property (
        @(posedge clk) disable iff (rst)
        (retire[0].valid && (retire[0].rd_arch != '0))
            |-> (retire[0].rd_phy_old == committed_map[retire[0].rd_arch])
    );

    a_old_match1: assert property (
        @(posedge clk) disable iff (rst)
        (retire[1].valid && (retire[1].rd_arch != '0)) |-> (retire[1].rd_phy_old == old_exp1)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rename_unit -f vlog.f -o tb_rename_unit
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_rename_unit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* spec_map_table.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module spec_map_table (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  rename_pkg::rename_req_t req [`RENAME_W],
    input  logic                    req_ready,
    input  rename_pkg::phys_reg_t   alloc_phys [`RENAME_W],
    input  rename_pkg::phys_reg_t   committed_map [`ARCH_REGS],
    output logic [1:0]              alloc,
    output rename_pkg::rename_rsp_t rsp [`RENAME_W]
);
    import rename_pkg::*;

    phys_reg_t spec_map [`ARCH_REGS];

    logic accept;
    logic wr0;
    logic wr1;
    logic byp_rs1;        // lane 1 source hits lane 0 destination
    logic byp_rs2;
    logic byp_rd;

    assign accept = req_ready && req[0].valid;

    // x0 destinations never allocate
    assign wr0 = req[0].valid && (req[0].rd_arch != '0);
    assign wr1 = req[1].valid && (req[1].rd_arch != '0);

    assign alloc[0] = accept && wr0;
    assign alloc[1] = accept && wr1;

    assign byp_rs1 = wr0 && (req[1].rs1_arch == req[0].rd_arch);
    assign byp_rs2 = wr0 && (req[1].rs2_arch == req[0].rd_arch);
    assign byp_rd  = wr0 && (req[1].rd_arch == req[0].rd_arch);

    always_comb begin
        // lane 0 reads the table directly
        rsp[0].rs1_phy    = spec_map[req[0].rs1_arch];
        rsp[0].rs2_phy    = spec_map[req[0].rs2_arch];
        rsp[0].rd_phy_old = wr0 ? spec_map[req[0].rd_arch] : '0;
        rsp[0].rd_phy_new = wr0 ? alloc_phys[0] : '0;

        // lane 1 sees what lane 0 writes in the same group
        rsp[1].rs1_phy = byp_rs1 ? alloc_phys[0] : spec_map[req[1].rs1_arch];
        rsp[1].rs2_phy = byp_rs2 ? alloc_phys[0] : spec_map[req[1].rs2_arch];
        if (!wr1) begin
            rsp[1].rd_phy_old = '0;
        end else if (byp_rd) begin
            rsp[1].rd_phy_old = alloc_phys[0];
        end else begin
            rsp[1].rd_phy_old = spec_map[req[1].rd_arch];
        end
        rsp[1].rd_phy_new = wr1 ? alloc_phys[1] : '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= phys_reg_t'(i);    // identity after reset
            end
        end else if (flush) begin
            spec_map <= committed_map;             // back to the retired state
        end else if (accept) begin
            if (wr0) begin
                spec_map[req[0].rd_arch] <= alloc_phys[0];
            end
            if (wr1) begin
                spec_map[req[1].rd_arch] <= alloc_phys[1];  // later lane wins
            end
        end
    end

    a_lane_order: assert property (
        @(posedge clk) disable iff (rst)
        req[1].valid |-> req[0].valid
    );

endmodule

/* tb_rename_unit.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module tb_rename_unit;
    import rename_pkg::*;

    localparam int NUM_CYCLES     = 3000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 20 * (`PHY_REGS + 2);

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    rename_req_t req [`RENAME_W];
    retire_t     retire [`RENAME_W];
    logic        req_ready;
    rename_rsp_t rsp [`RENAME_W];

    // reference model
    phys_reg_t spec_m [`ARCH_REGS];
    phys_reg_t ret_m  [`ARCH_REGS];
    phys_reg_t free_q [$];             // FIFO of free physical registers
    retire_t   inflight [$];           // accepted renames in program order
    int        rebuild_left = 0;       // cycles of rebuild still ahead
    logic      accepted;
    int        n_flush     = 0;
    int        n_bypass    = 0;
    int        cycle_cnt   = 0;

    rename_unit i_dut (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req       (req),
        .retire    (retire),
        .req_ready (req_ready),
        .rsp       (rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reset_model();
        for (int a = 0; a < `ARCH_REGS; a++) begin
            spec_m[a] = phys_reg_t'(a);
            ret_m[a]  = phys_reg_t'(a);
        end
        free_q.delete();
        for (int p = `ARCH_REGS; p < `PHY_REGS; p++) begin
            free_q.push_back(phys_reg_t'(p));
        end
        inflight.delete();
    endtask

    task automatic pick_stimulus();
        rename_req_t r [`RENAME_W];
        retire_t     t [`RENAME_W];
        logic        f;
        int          n_grp;
        int          n_ret;
        f     = (rebuild_left == 0) && (($urandom % 150) == 0);
        n_grp = ($urandom % 4 == 0) ? 0 : (($urandom % 3 == 0) ? 1 : 2);
        n_ret = $urandom % 3;
        if (n_ret > inflight.size()) begin
            n_ret = inflight.size();
        end
        if (f) begin
            n_grp = 0;          // flush goes out alone
            n_ret = 0;
        end
        for (int k = 0; k < `RENAME_W; k++) begin
            r[k].valid    = (k < n_grp);
            r[k].rd_arch  = ($urandom % 8 == 0) ? '0 : arch_reg_t'($urandom);
            r[k].rs1_arch = arch_reg_t'($urandom);
            r[k].rs2_arch = arch_reg_t'($urandom);
        end
        // steer lane 1 onto lane 0's destination now and then
        if ($urandom % 3 == 0) r[1].rs1_arch = r[0].rd_arch;
        if ($urandom % 4 == 0) r[1].rs2_arch = r[0].rd_arch;
        if ($urandom % 4 == 0) r[1].rd_arch = r[0].rd_arch;
        for (int k = 0; k < `RENAME_W; k++) begin
            t[k] = '0;
            if (k < n_ret) begin
                t[k] = inflight[k];
            end
            req[k]    <= r[k];
            retire[k] <= t[k];
        end
        flush <= f;
    endtask

    task automatic check_outputs();
        phys_reg_t m [`ARCH_REGS];
        int        idx;
        logic      exp_ready;
        phys_reg_t e_old;
        phys_reg_t e_new;
        exp_ready = (rebuild_left == 0) && (free_q.size() >= 2);
        check_value("req_ready", 32'(req_ready), 32'(exp_ready));
        accepted = exp_ready && req[0].valid;
        if (!accepted) return;
        m   = spec_m;
        idx = 0;
        for (int k = 0; k < `RENAME_W; k++) begin
            if (req[k].valid) begin
                check_value($sformatf("rsp[%0d].rs1_phy", k), 32'(rsp[k].rs1_phy),
                            32'(m[req[k].rs1_arch]));
                check_value($sformatf("rsp[%0d].rs2_phy", k), 32'(rsp[k].rs2_phy),
                            32'(m[req[k].rs2_arch]));
                e_old = '0;
                e_new = '0;
                if (req[k].rd_arch != '0) begin
                    e_old = m[req[k].rd_arch];
                    e_new = free_q[idx];    // next entry in FIFO order
                    idx++;
                    m[req[k].rd_arch] = e_new;
                end
                check_value($sformatf("rsp[%0d].rd_phy_old", k), 32'(rsp[k].rd_phy_old),
                            32'(e_old));
                check_value($sformatf("rsp[%0d].rd_phy_new", k), 32'(rsp[k].rd_phy_new),
                            32'(e_new));
            end
        end
        if (req[1].valid && req[0].rd_arch != '0 &&
            (req[1].rs1_arch == req[0].rd_arch || req[1].rs2_arch == req[0].rd_arch ||
             req[1].rd_arch == req[0].rd_arch)) begin
            n_bypass++;
        end
    endtask

    task automatic update_model();
        retire_t              e;
        logic [`PHY_REGS-1:0] held;
        if (flush) begin
            spec_m = ret_m;
            inflight.delete();
            free_q.delete();
            held = '0;
            for (int a = 0; a < `ARCH_REGS; a++) begin
                held[ret_m[a]] = 1'b1;
            end
            // ascending rebuild order that skips register 0
            for (int p = 1; p < `PHY_REGS; p++) begin
                if (!held[p]) free_q.push_back(phys_reg_t'(p));
            end
            rebuild_left = `PHY_REGS;
            n_flush++;
        end else begin
            if (rebuild_left > 0) rebuild_left--;
            for (int k = 0; k < `RENAME_W; k++) begin
                if (accepted && req[k].valid) begin
                    e = '0;
                    e.valid   = 1'b1;
                    e.rd_arch = req[k].rd_arch;
                    if (req[k].rd_arch != '0) begin
                        e.rd_phy_old = spec_m[req[k].rd_arch];
                        e.rd_phy_new = free_q.pop_front();
                        spec_m[req[k].rd_arch] = e.rd_phy_new;
                    end
                    inflight.push_back(e);
                end
            end
            for (int k = 0; k < `RENAME_W; k++) begin
                if (retire[k].valid) begin
                    e = inflight.pop_front();
                    if (e.rd_arch != '0) begin
                        ret_m[e.rd_arch] = e.rd_phy_new;
                        free_q.push_back(e.rd_phy_old);   // lane 0 first
                    end
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'hacab));
        rst   = 1'b1;
        flush = 1'b0;
        for (int k = 0; k < `RENAME_W; k++) begin
            req[k]    = '0;
            retire[k] = '0;
        end
        reset_model();
        repeat (10) begin
            @(negedge clk);
            check_value("req_ready", 32'(req_ready), 32'h0);
        end
        @(posedge clk);
        rst <= 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk);
            pick_stimulus();
            @(negedge clk);
            check_outputs();
            update_model();
        end
        if (n_flush == 0 || n_bypass == 0) begin
            $display("the random run never reached a flush or a lane 1 bypass");
            $display("SOME TESTS FAILED");
            $fatal(1, "stimulus too narrow");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+.
rename_pkg.sv
free_list.sv
spec_map_table.sv
retire_map_table.sv
rename_unit.sv
tb_rename_unit.sv
